//--- sim.f
src/tx_stream_pkg.sv
src/tx_req_ctrl.sv
src/tx_frame_packer.sv
src/tx_sync_fifo.sv
src/tx_out_stage.sv
src/tx_stream_top.sv
tb/tb_tx_stream.sv

//--- src/tx_frame_packer.sv
// tx frame packer: captures header attributes and builds flagged 64-bit stream words for the FIFO
`default_nettype none
`timescale 1ns/1ns

module tx_frame_packer (
   input  logic                             clk_in,
   input  logic                             srst,
   input  logic                             tx_req,
   input  logic [tx_stream_pkg::DESC_W-1:0] tx_desc,
   input  logic                             tx_dv,
   input  logic                             tx_dfr,
   input  logic                             tx_err,
   input  logic [tx_stream_pkg::DATA_W-1:0] tx_data,
   input  logic                             tx_ack,
   input  logic                             tx_ws,
   input  logic                             req_pending,
   output logic                             wait_for_desc,
   output logic                             fifo_wr,
   output logic [tx_stream_pkg::WORD_W-1:0] fifo_wdata
);
   import tx_stream_pkg::*;

   logic              req_d;
   logic              req_rise;
   logic              is_4dw_r;
   logic              has_data_r;
   logic [LEN_W-1:0]  len_r;
   logic              beat_ok;
   logic              word_wr;
   logic              word_eop;
   logic              eop_hdr;
   logic              eop_beat;
   logic [DATA_W-1:0] word_data;
   logic              desc_4dw;
   logic              desc_aligned;

   // ----------------------------------------
   // descriptor phase 1 and attribute capture
   // ----------------------------------------
   assign req_rise = tx_req && !req_d;

   // whole descriptor is stable from the first request cycle
   assign desc_4dw     = tx_desc[FMT_4DW_BIT];
   assign desc_aligned = desc_4dw ? (tx_desc[ADDR4_LSB +: ADDR_OFS_W] == '0)
                                  : (tx_desc[ADDR3_LSB +: ADDR_OFS_W] == '0);

   // attributes hold until the next request rises
   always_ff @(posedge clk_in) begin
      if (srst) begin
         req_d         <= 1'b0;
         is_4dw_r      <= 1'b0;
         has_data_r    <= 1'b0;
         len_r         <= '0;
         wait_for_desc <= 1'b0;
      end else begin
         req_d <= tx_req;
         if (req_rise) begin
            is_4dw_r      <= desc_4dw;
            has_data_r    <= tx_desc[FMT_DATA_BIT];
            // length only matters with a payload
            len_r         <= tx_desc[FMT_DATA_BIT] ? tx_desc[LEN_LSB +: LEN_W] : '0;
            wait_for_desc <= desc_4dw || desc_aligned;
         end
      end
   end

   // ----------------------------------------
   // word select and flags
   // ----------------------------------------
   assign beat_ok = tx_dv && !tx_ws;

   // phase 1, phase 2, or an accepted data beat
   assign word_wr = req_rise || tx_ack || beat_ok;

   // 3DW non-aligned with a payload is the only case that merges D0
   always_comb begin
      if (req_rise) begin
         word_data = tx_desc[DESC_W-1 -: DATA_W];            // H0 H1
      end else if (req_pending && is_4dw_r) begin
         word_data = tx_desc[DATA_W-1:0];                    // H2 H3
      end else if (req_pending && (wait_for_desc || !has_data_r)) begin
         word_data = {tx_desc[DATA_W-1 -: 32], 32'h0};       // H2, empty slot
      end else if (req_pending) begin
         word_data = {tx_desc[DATA_W-1 -: 32], tx_data[63:32]};  // H2 D0 merge
      end else begin
         // payload beat, dwords swapped
         word_data = {tx_data[31:0], tx_data[63:32]};
      end
   end

   // phase 2 closes a dataless TLP or a 3DW non-aligned single dword
   assign eop_hdr = tx_ack && (!has_data_r || (!wait_for_desc && len_r == LEN_W'(1)));

   // last accepted beat, unless D0 already went out in phase 2 as the only dword
   assign eop_beat = beat_ok && !tx_dfr && (wait_for_desc || len_r > LEN_W'(1));

   assign word_eop = eop_hdr || eop_beat;

   // ----------------------------------------
   // registered FIFO write
   // ----------------------------------------
   always_ff @(posedge clk_in) begin
      if (srst) begin
         fifo_wr <= 1'b0;
      end else begin
         fifo_wr <= word_wr;
      end
   end

   // payload register, err taken in the same cycle as its word
   always_ff @(posedge clk_in) begin
      fifo_wdata[DATA_W-1:0] <= word_data;
      fifo_wdata[WORD_EOP]   <= word_eop;
      fifo_wdata[WORD_SOP]   <= req_rise;
      fifo_wdata[WORD_ERR]   <= tx_err;
   end

endmodule

`default_nettype wire

//--- src/tx_out_stage.sv
// tx output stage: one-word register driving the valid/ready stream and popping the FIFO
`default_nettype none
`timescale 1ns/1ns

module tx_out_stage (
   input  logic                             clk_in,
   input  logic                             srst,
   input  logic [tx_stream_pkg::WORD_W-1:0] fifo_rdata,
   input  logic                             fifo_empty,
   input  logic                             tx_ready,
   output logic                             fifo_rd,
   output logic [tx_stream_pkg::WORD_W-1:0] word_out,
   output logic                             tx_valid
);

   // stage can take a word when it is empty or its word leaves this cycle
   assign fifo_rd = !fifo_empty && (!tx_valid || tx_ready);

   // ----------------------------------------
   // valid flag
   // ----------------------------------------
   always_ff @(posedge clk_in) begin
      if (srst) begin
         tx_valid <= 1'b0;
      end else if (fifo_rd) begin
         tx_valid <= 1'b1;
      end else if (tx_ready) begin
         // word taken and nothing to refill
         tx_valid <= 1'b0;
      end
   end

   // word register, only loads on a pop so it holds while ready is low
   always_ff @(posedge clk_in) begin
      if (fifo_rd) begin
         word_out <= fifo_rdata;
      end
   end

endmodule

`default_nettype wire

//--- src/tx_req_ctrl.sv
// tx request control: tracks the descriptor request, grants ack and drives the data wait-state
`default_nettype none
`timescale 1ns/1ns

module tx_req_ctrl (
   input  logic                               clk_in,
   input  logic                               srst,
   input  logic                               tx_req,
   input  logic                               wait_for_desc,
   input  logic [tx_stream_pkg::TX_FIFO_AW-1:0] fifo_count,
   input  logic                               fifo_empty,
   output logic                               tx_ack,
   output logic                               tx_ws,
   output logic                               req_pending
);
   import tx_stream_pkg::*;

   logic almost_full;
   logic almost_full_r;
   logic ack_window;

   // ----------------------------------------
   // request pending flag
   // ----------------------------------------
   // set by the request, cleared in the ack cycle
   // ack has priority so a still-high request does not re-arm it
   always_ff @(posedge clk_in) begin
      if (srst) begin
         req_pending <= 1'b0;
      end else if (tx_ack) begin
         req_pending <= 1'b0;
      end else if (tx_req) begin
         req_pending <= 1'b1;
      end
   end

   // ----------------------------------------
   // almost-full tracking
   // ----------------------------------------
   // count wraps at full depth, so qualify with not empty
   always_ff @(posedge clk_in) begin
      if (srst) begin
         almost_full   <= 1'b0;
         almost_full_r <= 1'b0;
      end else begin
         almost_full   <= (fifo_count > ALMOST_FULL_LEVEL) && !fifo_empty;
         almost_full_r <= almost_full;
      end
   end

   // ack allowed below the level, or in the one cycle where almost-full first rises
   // (the grace cycle lets a descriptor already granted complete its two words)
   assign ack_window = !almost_full || (almost_full && !almost_full_r);

   // pending is only set one edge after phase 1, so ack can never come earlier
   assign tx_ack = req_pending && ack_window;

   // hold data while the FIFO is filling up
   // also hold it until the header is written for 4DW or aligned headers,
   // since their payload starts only after phase 2
   assign tx_ws = almost_full || (req_pending && wait_for_desc);

endmodule

`default_nettype wire

//--- src/tx_stream_pkg.sv
// tx stream package: widths, header field positions, FIFO sizing and stream word layout
`default_nettype none

package tx_stream_pkg;

   // ----------------------------------------
   // descriptor and data widths
   // ----------------------------------------
   localparam int DESC_W = 128;     // full 4DW TLP header
   localparam int DATA_W = 64;      // one stream word, two dwords
   localparam int LEN_W  = 10;      // TLP length in dwords

   // header fields, positions inside the 128-bit descriptor
   localparam int FMT_4DW_BIT  = 125;   // fmt[0], set for a 4DW header
   localparam int FMT_DATA_BIT = 126;   // fmt[1], set when a payload follows
   localparam int LEN_LSB      = 96;    // length field in H0
   // address offset within a qword
   // 3DW: address sits in H2, 4DW: low address sits in H3
   localparam int ADDR3_LSB  = 32;
   localparam int ADDR4_LSB  = 0;
   localparam int ADDR_OFS_W = 3;

   // ----------------------------------------
   // stream word layout
   // ----------------------------------------
   // [66] err  [65] sop  [64] eop  [63:0] data
   localparam int WORD_ERR = 66;
   localparam int WORD_SOP = 65;
   localparam int WORD_EOP = 64;
   localparam int WORD_W   = 67;

   // ----------------------------------------
   // FIFO sizing
   // ----------------------------------------
   localparam int TX_FIFO_DEPTH     = 32;
   localparam int TX_FIFO_AW        = 5;    // fill count width, wraps to 0 when full
   // above this level acks stop and data waits
   localparam int ALMOST_FULL_LEVEL = 16;

endpackage

`default_nettype wire

//--- src/tx_stream_top.sv
// tx stream top: connects request control, frame packer, FIFO and output stage
`default_nettype none
`timescale 1ns/1ns

module tx_stream_top (
   input  logic                             clk_in,
   input  logic                             srst,
   input  logic                             tx_req,
   input  logic [tx_stream_pkg::DESC_W-1:0] tx_desc,
   input  logic                             tx_dv,
   input  logic                             tx_dfr,
   input  logic                             tx_err,
   input  logic [tx_stream_pkg::DATA_W-1:0] tx_data,
   input  logic                             tx_ready,
   output logic                             tx_ack,
   output logic                             tx_ws,
   output logic [tx_stream_pkg::DATA_W-1:0] tx_data_out,
   output logic                             tx_sop,
   output logic                             tx_eop,
   output logic                             tx_err_out,
   output logic                             tx_valid,
   output logic                             tx_fifo_empty
);
   import tx_stream_pkg::*;

   logic                  req_pending;
   logic                  wait_for_desc;
   logic                  fifo_wr;
   logic [WORD_W-1:0]     fifo_wdata;
   logic                  fifo_rd;
   logic [WORD_W-1:0]     fifo_rdata;
   logic                  fifo_empty;
   logic [TX_FIFO_AW-1:0] fifo_count;
   logic [WORD_W-1:0]     word_out;

   // ----------------------------------------
   // input side
   // ----------------------------------------
   tx_req_ctrl i_req_ctrl (
      .clk_in        (clk_in),
      .srst          (srst),
      .tx_req        (tx_req),
      .wait_for_desc (wait_for_desc),
      .fifo_count    (fifo_count),
      .fifo_empty    (fifo_empty),
      .tx_ack        (tx_ack),
      .tx_ws         (tx_ws),
      .req_pending   (req_pending)
   );

   tx_frame_packer i_packer (
      .clk_in        (clk_in),
      .srst          (srst),
      .tx_req        (tx_req),
      .tx_desc       (tx_desc),
      .tx_dv         (tx_dv),
      .tx_dfr        (tx_dfr),
      .tx_err        (tx_err),
      .tx_data       (tx_data),
      .tx_ack        (tx_ack),
      .tx_ws         (tx_ws),
      .req_pending   (req_pending),
      .wait_for_desc (wait_for_desc),
      .fifo_wr       (fifo_wr),
      .fifo_wdata    (fifo_wdata)
   );

   // ----------------------------------------
   // buffer and output side
   // ----------------------------------------
   // full is not needed outside, the almost-full throttle keeps it away
   tx_sync_fifo #(
      .DEPTH (TX_FIFO_DEPTH),
      .WIDTH (WORD_W)
   ) i_fifo (
      .clk_in (clk_in),
      .srst   (srst),
      .wr     (fifo_wr),
      .wdata  (fifo_wdata),
      .rd     (fifo_rd),
      .rdata  (fifo_rdata),
      .empty  (fifo_empty),
      .full   (),
      .count  (fifo_count)
   );

   tx_out_stage i_out_stage (
      .clk_in     (clk_in),
      .srst       (srst),
      .fifo_rdata (fifo_rdata),
      .fifo_empty (fifo_empty),
      .tx_ready   (tx_ready),
      .fifo_rd    (fifo_rd),
      .word_out   (word_out),
      .tx_valid   (tx_valid)
   );

   // split the output word into data and flags
   assign tx_data_out   = word_out[DATA_W-1:0];
   assign tx_sop        = word_out[WORD_SOP];
   assign tx_eop        = word_out[WORD_EOP];
   assign tx_err_out    = word_out[WORD_ERR];
   assign tx_fifo_empty = fifo_empty;

endmodule

`default_nettype wire

//--- src/tx_sync_fifo.sv
// tx sync FIFO: show-ahead circular buffer with fill count and overflow/underflow protection
`default_nettype none
`timescale 1ns/1ns

module tx_sync_fifo #(
   parameter int DEPTH = tx_stream_pkg::TX_FIFO_DEPTH,
   parameter int WIDTH = tx_stream_pkg::WORD_W
) (
   input  logic                     clk_in,
   input  logic                     srst,
   input  logic                     wr,
   input  logic [WIDTH-1:0]         wdata,
   input  logic                     rd,
   output logic [WIDTH-1:0]         rdata,
   output logic                     empty,
   output logic                     full,
   output logic [$clog2(DEPTH)-1:0] count
);

   localparam int AW = $clog2(DEPTH);

   logic [WIDTH-1:0] mem [DEPTH];
   logic [AW-1:0]    wr_ptr;
   logic [AW-1:0]    rd_ptr;
   logic [AW:0]      fill;     // one extra bit to tell full from empty
   logic             do_wr;
   logic             do_rd;

   // drop writes when full, reads when empty
   assign do_wr = wr && !full;
   assign do_rd = rd && !empty;

   // ----------------------------------------
   // pointers and fill level
   // ----------------------------------------
   // pointers wrap naturally, depth is a power of two
   always_ff @(posedge clk_in) begin
      if (srst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         fill   <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         // simultaneous push and pop leave the level unchanged
         if (do_wr && !do_rd) begin
            fill <= fill + 1'b1;
         end else if (do_rd && !do_wr) begin
            fill <= fill - 1'b1;
         end
      end
   end

   // storage, no reset
   always_ff @(posedge clk_in) begin
      if (do_wr) begin
         mem[wr_ptr] <= wdata;
      end
   end

   // ----------------------------------------
   // status and show-ahead head word
   // ----------------------------------------
   assign empty = (fill == '0);
   assign full  = (fill == (AW+1)'(DEPTH));
   assign count = fill[AW-1:0];     // wraps to 0 at full depth

   // head word visible the cycle after it is written
   assign rdata = mem[rd_ptr];

endmodule

`default_nettype wire

//--- tb/tb_tx_stream.sv
// testbench for the tx stream packer: random TLPs against an expected-word scoreboard
`default_nettype none
`timescale 1ns/1ns

module tb_tx_stream;
   import tx_stream_pkg::*;

   localparam int  CLK_PERIOD   = 40;
   localparam int  RESET_CYCLES = 10;
   localparam int  NUM_TLP      = 120;
   localparam int  DRAIN_CYCLES = 2000;
   // 12 words per TLP at worst, 4 cycles each
   localparam time TIMEOUT      = NUM_TLP * 12 * 4 * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD;

   logic              clk_in;
   logic              srst;
   logic              tx_req;
   logic [DESC_W-1:0] tx_desc;
   logic              tx_dv;
   logic              tx_dfr;
   logic              tx_err;
   logic [DATA_W-1:0] tx_data;
   logic              tx_ready;
   logic              tx_ack;
   logic              tx_ws;
   logic [DATA_W-1:0] tx_data_out;
   logic              tx_sop;
   logic              tx_eop;
   logic              tx_err_out;
   logic              tx_valid;
   logic              tx_fifo_empty;

   integer            seed;
   integer            ready_seed;
   logic [WORD_W-1:0] exp_q [$];
   logic [WORD_W-1:0] got;
   logic [WORD_W-1:0] exp_word;
   logic [WORD_W-1:0] word_prev;
   logic              stall_prev;
   logic              ws_seen;
   int                value_errors;
   int                other_errors;
   int                words_checked;

   tx_stream_top i_dut (
      .clk_in        (clk_in),
      .srst          (srst),
      .tx_req        (tx_req),
      .tx_desc       (tx_desc),
      .tx_dv         (tx_dv),
      .tx_dfr        (tx_dfr),
      .tx_err        (tx_err),
      .tx_data       (tx_data),
      .tx_ready      (tx_ready),
      .tx_ack        (tx_ack),
      .tx_ws         (tx_ws),
      .tx_data_out   (tx_data_out),
      .tx_sop        (tx_sop),
      .tx_eop        (tx_eop),
      .tx_err_out    (tx_err_out),
      .tx_valid      (tx_valid),
      .tx_fifo_empty (tx_fifo_empty)
   );

   initial begin
      clk_in = 1'b0;
      forever #(CLK_PERIOD / 2) clk_in = ~clk_in;
   end

   // ----------------------------------------
   // helpers
   // ----------------------------------------
   // stream word as {err, sop, eop, data}
   function automatic logic [WORD_W-1:0] make_word(input logic err, input logic sop,
                                                   input logic eop, input logic [DATA_W-1:0] d);
      return {err, sop, eop, d};
   endfunction

   task automatic check_idle_outputs(input string phase_txt);
      assert (tx_ack === 1'b0 && tx_ws === 1'b0 && tx_valid === 1'b0 && tx_fifo_empty === 1'b1)
      else begin
         $display("Fail at %0t: outputs not idle %s, ack=%b ws=%b valid=%b empty=%b",
                  $time, phase_txt, tx_ack, tx_ws, tx_valid, tx_fifo_empty);
         value_errors++;
      end
   endtask

   // one TLP: descriptor handshake, then payload beats under wait-states
   task automatic send_tlp();
      logic [DESC_W-1:0] desc;
      logic [DATA_W-1:0] beat;
      logic [DATA_W-1:0] hdr2;
      logic              is4;
      logic              has_data;
      logic              aligned;
      logic              last;
      logic              early;
      int                len;
      int                nbeats;
      len      = $unsigned($random(seed)) % 9;
      has_data = (len != 0);
      is4      = $random(seed);
      aligned  = $random(seed);
      desc     = {$random(seed), $random(seed), $random(seed), $random(seed)};
      desc[FMT_DATA_BIT]          = has_data;
      desc[FMT_4DW_BIT]           = is4;
      desc[LEN_LSB +: LEN_W]      = LEN_W'(len);
      desc[ADDR3_LSB +: ADDR_OFS_W] = 3'd1 + 3'($unsigned($random(seed)) % 7);
      desc[ADDR4_LSB +: ADDR_OFS_W] = 3'd1 + 3'($unsigned($random(seed)) % 7);
      if (aligned && is4) begin
         desc[ADDR4_LSB +: ADDR_OFS_W] = '0;
      end else if (aligned) begin
         desc[ADDR3_LSB +: ADDR_OFS_W] = '0;
      end
      // D0 rides in the upper dword, a dataless TLP must not pick it up
      beat = {$random(seed), $random(seed)};

      // phase 1, H0H1 with sop
      @(negedge clk_in);
      tx_req  = 1'b1;
      tx_desc = desc;
      tx_data = beat;
      tx_dv   = 1'b0;
      tx_err  = $random(seed);
      exp_q.push_back(make_word(tx_err, 1'b1, 1'b0, desc[DESC_W-1 -: DATA_W]));

      // phase 2 on the ack cycle
      @(negedge clk_in);
      tx_err = $random(seed);
      // merged D0 already sent, the rest goes two dwords per beat
      nbeats = !has_data ? 0 : (!is4 && !aligned) ? len / 2 : (len + 1) / 2;
      // 4DW and aligned payloads offer the first beat while the request is pending,
      // ws has to hold it off until after the ack
      early = (nbeats > 0) && (is4 || aligned);
      if (early) begin
         beat    = {$random(seed), $random(seed)};
         tx_dv   = 1'b1;
         tx_data = beat;
         tx_dfr  = (nbeats > 1);
      end
      while (!tx_ack) @(negedge clk_in);
      if (is4) begin
         hdr2 = desc[DATA_W-1:0];
      end else if (!has_data || aligned) begin
         hdr2 = {desc[63:32], 32'h0};
      end else begin
         hdr2 = {desc[63:32], beat[63:32]};
      end
      last = !has_data || (!is4 && !aligned && len == 1);
      exp_q.push_back(make_word(tx_err, 1'b0, last, hdr2));
      @(negedge clk_in);
      tx_req = 1'b0;

      for (int i = 0; i < nbeats; i++) begin
         if (i > 0 || !early) begin
            beat    = {$random(seed), $random(seed)};
            tx_dv   = 1'b1;
            tx_data = beat;
            tx_dfr  = (i < nbeats - 1);
         end
         tx_err = $random(seed);
         // ws only moves on the rising edge
         while (tx_ws) @(negedge clk_in);
         exp_q.push_back(make_word(tx_err, 1'b0, !tx_dfr, {beat[31:0], beat[63:32]}));
         @(negedge clk_in);
      end
      tx_dv  = 1'b0;
      tx_dfr = 1'b0;
   endtask

   // ----------------------------------------
   // output monitor
   // ----------------------------------------
   // posedge samples see the values from before the edge
   always @(posedge clk_in) begin
      if (srst) begin
         stall_prev = 1'b0;
      end else begin
         got = make_word(tx_err_out, tx_sop, tx_eop, tx_data_out);
         // no request pending, so ws can only come from almost-full
         if (tx_ws && !tx_req) ws_seen = 1'b1;
         if (stall_prev) begin
            assert (tx_valid === 1'b1 && got === word_prev) else begin
               $display("Fail at %0t: output moved while ready was low, got %h held %h",
                        $time, got, word_prev);
               value_errors++;
            end
         end
         if (tx_valid && tx_ready) begin
            if (exp_q.size() == 0) begin
               $display("word %h left the stream at %0t with nothing expected", got, $time);
               other_errors++;
            end else begin
               exp_word = exp_q.pop_front();
               words_checked++;
               assert (got === exp_word) else begin
                  $display("Fail at %0t: word %0d got err/sop/eop %b data %h, expected %b data %h",
                           $time, words_checked, got[WORD_ERR -: 3], got[DATA_W-1:0],
                           exp_word[WORD_ERR -: 3], exp_word[DATA_W-1:0]);
                  value_errors++;
               end
            end
         end
         stall_prev = tx_valid && !tx_ready;
         word_prev  = got;
      end
   end

   // ready pattern, long low stretches to fill the FIFO
   initial begin
      ready_seed = 32'h18cf + 1;
      repeat (RESET_CYCLES + 1) @(negedge clk_in);
      forever begin
         tx_ready = 1'b1;
         repeat (1 + $unsigned($random(ready_seed)) % 20) @(negedge clk_in);
         tx_ready = 1'b0;
         repeat ($unsigned($random(ready_seed)) % 48) @(negedge clk_in);
      end
   end

   // watchdog
   initial begin
      #(TIMEOUT);
      $display("timeout after %0t, the stream stopped before all words came out", $time);
      $display("Errors found");
      $finish;
   end

   // ----------------------------------------
   // main sequence
   // ----------------------------------------
   initial begin
      seed          = 32'h18cf;
      srst          = 1'b1;
      tx_req        = 1'b0;
      tx_desc       = '0;
      tx_dv         = 1'b0;
      tx_dfr        = 1'b0;
      tx_err        = 1'b0;
      tx_data       = '0;
      tx_ready      = 1'b0;
      ws_seen       = 1'b0;
      value_errors  = 0;
      other_errors  = 0;
      words_checked = 0;
      repeat (RESET_CYCLES) @(negedge clk_in);
      check_idle_outputs("during reset");
      srst = 1'b0;
      @(negedge clk_in);
      check_idle_outputs("after reset");

      for (int t = 0; t < NUM_TLP; t++) begin
         send_tlp();
         repeat ($unsigned($random(seed)) % 3) @(negedge clk_in);
      end

      // let the stream drain
      for (int c = 0; c < DRAIN_CYCLES && exp_q.size() != 0; c++) @(negedge clk_in);
      repeat (8) @(negedge clk_in);
      if (exp_q.size() != 0) begin
         $display("%0d expected words never came out of the stream", exp_q.size());
         other_errors++;
      end
      assert (ws_seen) else begin
         $display("tx_ws never went high, the FIFO was never pushed past almost-full");
         other_errors++;
      end

      $display("summary: %0d words checked, %0d value errors, %0d other errors",
               words_checked, value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire
